//--- verilog.f
rtl/regfile_cfg_pkg.sv
rtl/regfile_bus_pkg.sv
rtl/regfile_cpu_port.sv
rtl/regfile_array.sv
rtl/regfile_dp_top.sv
testbench/tb_clock_gen.sv
testbench/regfile_dp_assertions.sv
testbench/regfile_dp_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the register file testbench with Verilator
# a failing run ends in $fatal, which gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module regfile_dp_tb \
   -f verilog.f \
   -o sim_regfile_dp

./obj_dir/sim_regfile_dp +verilator+error+limit+1000

//--- testbench/regfile_dp_tb.sv
`timescale 1ns/1ps

module regfile_dp_tb
   import regfile_cfg_pkg::*;
   import regfile_bus_pkg::*;
();

   localparam int WAIT_LIMIT = 20; // cycles per bounded wait

   logic        clk;
   logic        arst_n;
   logic        cke;
   cpu_req_t    cpu_req;
   cpu_resp_t   cpu_resp;
   logic_req_t  logic_req;
   logic_resp_t logic_resp;

   int                seed;
   logic [31:0]       rnd;
   logic [ADDR_W-1:0] addr;
   logic [STRB_W-1:0] strb;
   logic [DATA_W-1:0] cpu_word;
   logic [DATA_W-1:0] logic_word;

   tb_clock_gen u_clock_gen (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   regfile_dp_top dut (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .cke_i        (cke),
      .cpu_req_i    (cpu_req),
      .cpu_resp_o   (cpu_resp),
      .logic_req_i  (logic_req),
      .logic_resp_o (logic_resp)
   );

   bind regfile_dp_top regfile_dp_assertions u_assertions (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cke_i        (cke_i),
      .cpu_req_i    (cpu_req_i),
      .cpu_resp_i   (cpu_resp_o),
      .logic_req_i  (logic_req_i),
      .logic_resp_i (logic_resp_o)
   );

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped after a failure");
   endtask

   // all tasks start and end 1 ns after a rising edge
   task automatic wait_cycle();
      @(posedge clk);
      #1;
   endtask

   // ready depends on inputs only and is stable at the edge
   task automatic wait_cpu_accept();
      int n;
      n = 0;
      @(posedge clk);
      while (!cpu_resp.ready && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (!cpu_resp.ready) begin
         fail_run("timeout waiting for cpu ready");
      end else begin
         #1;
         cpu_req = '0;
      end
   endtask

   task automatic wait_cpu_rvalid();
      int n;
      n = 0;
      while (!cpu_resp.rvalid && n < WAIT_LIMIT) begin
         wait_cycle();
         n++;
      end
      if (!cpu_resp.rvalid) begin
         fail_run("timeout waiting for cpu rvalid");
      end
   endtask

   task automatic wait_logic_rvalid();
      int n;
      n = 0;
      while (!logic_resp.rvalid && n < WAIT_LIMIT) begin
         wait_cycle();
         n++;
      end
      if (!logic_resp.rvalid) begin
         fail_run("timeout waiting for logic rvalid");
      end
   endtask

   // zero strobe is a read
   task automatic cpu_access(input logic [ADDR_W-1:0] a, input logic [STRB_W-1:0] s,
                             input logic [DATA_W-1:0] d);
      cpu_req.valid = 1'b1;
      cpu_req.addr  = a;
      cpu_req.wstrb = s;
      cpu_req.wdata = d;
      wait_cpu_accept();
      if (s == '0) begin
         wait_cpu_rvalid();
      end
   endtask

   task automatic logic_access(input logic we, input logic [ADDR_W-1:0] a,
                               input logic [DATA_W-1:0] d);
      logic_req.valid = 1'b1;
      logic_req.we    = we;
      logic_req.addr  = a;
      logic_req.wdata = d;
      wait_cycle(); // no back-pressure
      logic_req = '0;
      if (!we) begin
         wait_logic_rvalid();
      end
   endtask

   task automatic read_all_regs();
      for (int i = 0; i < N_REGS; i++) begin
         cpu_access(ADDR_W'(i), '0, '0);
         logic_access(1'b0, ADDR_W'(i), '0);
      end
   endtask

   task automatic pick_addr();
      rnd  = $random(seed);
      addr = rnd[ADDR_W-1:0];
   endtask

   always @(posedge clk) begin
      if (dut.u_assertions.any_failed) begin
         fail_run("an assertion on the DUT outputs failed");
      end
   end

   initial begin
      int n;
      seed      = 55;
      cke       = 1'b1;
      cpu_req   = '0;
      logic_req = '0;

      n = 0;
      while (!arst_n && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (!arst_n) begin
         fail_run("timeout waiting for reset release");
      end
      #1;

      read_all_regs(); // everything zero after reset

      // full word write and read back on both ports
      pick_addr();
      cpu_word = $random(seed);
      cpu_access(addr, '1, cpu_word);
      cpu_access(addr, '0, '0);
      logic_access(1'b0, addr, '0);

      // byte merge with random strobes
      repeat (24) begin
         pick_addr();
         rnd      = $random(seed);
         strb     = rnd[STRB_W-1:0];
         cpu_word = $random(seed);
         if (strb == '0) begin
            strb[0] = 1'b1;
         end
         cpu_access(addr, strb, cpu_word);
         cpu_access(addr, '0, '0);
      end

      // logic write then cpu read
      repeat (4) begin
         pick_addr();
         logic_word = $random(seed);
         logic_access(1'b1, addr, logic_word);
         cpu_access(addr, '0, '0);
      end

      // both ports write one register in the same cycle
      pick_addr();
      cpu_word      = $random(seed);
      logic_word    = $random(seed);
      cpu_req.valid = 1'b1;
      cpu_req.addr  = addr;
      cpu_req.wstrb = '1;
      cpu_req.wdata = cpu_word;
      logic_req.valid = 1'b1;
      logic_req.we    = 1'b1;
      logic_req.addr  = addr;
      logic_req.wdata = logic_word;
      wait_cycle();         // conflict edge, cpu held off
      logic_req.we = 1'b0;  // logic read sees the logic value
      wait_cpu_accept();    // retried cpu write goes in now
      logic_req = '0;
      wait_logic_rvalid();
      cpu_access(addr, '0, '0);

      // clock enable low freezes everything
      wait_cycle();
      pick_addr();
      cke             = 1'b0;
      cpu_req.valid   = 1'b1;
      cpu_req.addr    = addr;
      cpu_req.wstrb   = '0;
      logic_req.valid = 1'b1;
      logic_req.we    = 1'b1;
      logic_req.addr  = addr;
      logic_req.wdata = $random(seed);
      repeat (2) wait_cycle();
      logic_req.we = 1'b0; // frozen logic read gives no rvalid
      repeat (2) wait_cycle();
      cpu_req   = '0;
      logic_req = '0;
      cke       = 1'b1;
      read_all_regs();

      repeat (2) wait_cycle();
      if (dut.u_assertions.any_failed) begin
         fail_run("an assertion on the DUT outputs failed");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

//--- testbench/regfile_dp_assertions.sv
`timescale 1ns/1ps

module regfile_dp_assertions
   import regfile_cfg_pkg::*;
   import regfile_bus_pkg::*;
(
   input logic        clk_i,
   input logic        arst_n_i,
   input logic        cke_i,
   input cpu_req_t    cpu_req_i,
   input cpu_resp_t   cpu_resp_i,
   input logic_req_t  logic_req_i,
   input logic_resp_t logic_resp_i
);

   logic [DATA_W-1:0] shadow [N_REGS]; // reference copy of the registers
   logic              cpu_wr_req;
   logic              cpu_acc;
   logic              logic_wr;
   logic              logic_rd;
   logic              exp_ready;
   logic              exp_cpu_rvalid;
   logic [DATA_W-1:0] exp_cpu_rdata;
   logic              exp_logic_rvalid;
   logic [DATA_W-1:0] exp_logic_rdata;

   // sticky, one per property
   logic reset_bad        = 1'b0;
   logic ready_bad        = 1'b0;
   logic cpu_rvalid_bad   = 1'b0;
   logic cpu_rdata_bad    = 1'b0;
   logic logic_rvalid_bad = 1'b0;
   logic logic_rdata_bad  = 1'b0;
   logic any_failed;

   // strobed lanes take the new byte and the others keep the old one
   function automatic logic [DATA_W-1:0] apply_strobe(
      input logic [DATA_W-1:0] old_w,
      input logic [DATA_W-1:0] new_w,
      input logic [STRB_W-1:0] strb
   );
      logic [DATA_W-1:0] mask;
      mask = '0;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            mask[b*BYTE_W +: BYTE_W] = '1;
         end
      end
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   assign cpu_wr_req = cpu_req_i.valid & (|cpu_req_i.wstrb);
   assign cpu_acc    = cpu_req_i.valid & cpu_resp_i.ready & cke_i; // handshake seen at the port
   assign logic_wr   = logic_req_i.valid & logic_req_i.we;
   assign logic_rd   = logic_req_i.valid & ~logic_req_i.we;

   // ready drops with cke low or when both ports write one register
   assign exp_ready = cke_i & ~(logic_wr & cpu_wr_req & (logic_req_i.addr == cpu_req_i.addr));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < N_REGS; i++) begin
            shadow[i] <= '0;
         end
         exp_cpu_rvalid   <= 1'b0;
         exp_cpu_rdata    <= '0;
         exp_logic_rvalid <= 1'b0;
         exp_logic_rdata  <= '0;
      end else if (cke_i) begin
         exp_cpu_rvalid   <= cpu_acc & ~cpu_wr_req;
         exp_logic_rvalid <= logic_rd;
         if (cpu_acc && !cpu_wr_req) begin
            exp_cpu_rdata <= shadow[cpu_req_i.addr]; // old value
         end
         if (logic_rd) begin
            exp_logic_rdata <= shadow[logic_req_i.addr];
         end
         if (cpu_acc && cpu_wr_req) begin
            shadow[cpu_req_i.addr] <= apply_strobe(shadow[cpu_req_i.addr],
                                                   cpu_req_i.wdata, cpu_req_i.wstrb);
         end
         if (logic_wr) begin
            shadow[logic_req_i.addr] <= logic_req_i.wdata; // last write wins
         end
      end
   end

   assign any_failed = reset_bad | ready_bad | cpu_rvalid_bad | cpu_rdata_bad |
                       logic_rvalid_bad | logic_rdata_bad;

   a_reset_idle: assert property (@(posedge clk_i)
      !arst_n_i |-> (!cpu_resp_i.rvalid && !logic_resp_i.rvalid))
      else begin
         $error("CHECK FAILED t=%0t cpu_resp_o.rvalid/logic_resp_o.rvalid %s %b/%b",
                $time, "in reset expected 0/0 actual", cpu_resp_i.rvalid,
                logic_resp_i.rvalid);
         reset_bad = 1'b1;
      end

   a_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cpu_resp_i.ready == exp_ready)
      else begin
         $error("CHECK FAILED t=%0t cpu_resp_o.ready expected %b actual %b",
                $time, exp_ready, cpu_resp_i.ready);
         ready_bad = 1'b1;
      end

   a_cpu_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cpu_resp_i.rvalid == exp_cpu_rvalid)
      else begin
         $error("CHECK FAILED t=%0t cpu_resp_o.rvalid expected %b actual %b",
                $time, exp_cpu_rvalid, cpu_resp_i.rvalid);
         cpu_rvalid_bad = 1'b1;
      end

   a_cpu_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cpu_resp_i.rvalid |-> (cpu_resp_i.rdata == exp_cpu_rdata))
      else begin
         $error("CHECK FAILED t=%0t cpu_resp_o.rdata expected %h actual %h",
                $time, exp_cpu_rdata, cpu_resp_i.rdata);
         cpu_rdata_bad = 1'b1;
      end

   a_logic_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      logic_resp_i.rvalid == exp_logic_rvalid)
      else begin
         $error("CHECK FAILED t=%0t logic_resp_o.rvalid expected %b actual %b",
                $time, exp_logic_rvalid, logic_resp_i.rvalid);
         logic_rvalid_bad = 1'b1;
      end

   a_logic_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      logic_resp_i.rvalid |-> (logic_resp_i.rdata == exp_logic_rdata))
      else begin
         $error("CHECK FAILED t=%0t logic_resp_o.rdata expected %h actual %h",
                $time, exp_logic_rdata, logic_resp_i.rdata);
         logic_rdata_bad = 1'b1;
      end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic arst_n_o
);

   // 100 ns period
   initial begin
      clk_o = 1'b0;
      forever begin
         #50 clk_o = ~clk_o;
      end
   end

   // reset held for 8 rising edges, released just after the last one
   initial begin
      arst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      #1 arst_n_o = 1'b1;
   end

endmodule

//--- rtl/regfile_dp_top.sv
`timescale 1ns/1ps

module regfile_dp_top
   import regfile_cfg_pkg::*;
   import regfile_bus_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic        cke_i,

   // cpu bus
   input  cpu_req_t    cpu_req_i,
   output cpu_resp_t   cpu_resp_o,

   // core logic
   input  logic_req_t  logic_req_i,
   output logic_resp_t logic_resp_o
);

   logic [DATA_W-1:0] cpu_rword;
   logic              cpu_stall;
   logic              cpu_is_write;
   logic              cpu_wen;
   logic [ADDR_W-1:0] cpu_waddr;
   reg_word_u         cpu_wword;

   regfile_cpu_port u_cpu_port (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .cke_i      (cke_i),
      .req_i      (cpu_req_i),
      .resp_o     (cpu_resp_o),
      .stall_i    (cpu_stall),
      .rword_i    (cpu_rword),
      .is_write_o (cpu_is_write),
      .wen_o      (cpu_wen),
      .waddr_o    (cpu_waddr),
      .wword_o    (cpu_wword)
   );

   // waddr is the request address, used for reads too
   regfile_array u_array (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .cke_i          (cke_i),
      .cpu_addr_i     (cpu_waddr),
      .cpu_is_write_i (cpu_is_write),
      .cpu_wen_i      (cpu_wen),
      .cpu_wword_i    (cpu_wword),
      .cpu_rword_o    (cpu_rword),
      .cpu_stall_o    (cpu_stall),
      .logic_req_i    (logic_req_i),
      .logic_resp_o   (logic_resp_o)
   );

endmodule

//--- rtl/regfile_array.sv
`timescale 1ns/1ps

module regfile_array
   import regfile_cfg_pkg::*;
   import regfile_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              cke_i,

   // cpu side, already decoded by the port block
   input  logic [ADDR_W-1:0] cpu_addr_i,
   input  logic              cpu_is_write_i,
   input  logic              cpu_wen_i,
   input  reg_word_u         cpu_wword_i,
   output logic [DATA_W-1:0] cpu_rword_o,
   output logic              cpu_stall_o,

   // logic side
   input  logic_req_t        logic_req_i,
   output logic_resp_t       logic_resp_o
);

   logic [N_REGS-1:0][DATA_W-1:0] regs;
   logic                          logic_we;
   logic                          logic_rd;
   logic [N_REGS-1:0]             logic_hit;
   logic [N_REGS-1:0]             cpu_hit;
   logic                          rvalid_q;
   logic [DATA_W-1:0]             rdata_q;

   assign logic_we = logic_req_i.valid & logic_req_i.we;
   assign logic_rd = logic_req_i.valid & ~logic_req_i.we;

   // both ports writing one register, the logic port keeps it
   assign cpu_stall_o = logic_we & cpu_is_write_i & (logic_req_i.addr == cpu_addr_i);

   // per word write enables
   always_comb begin
      for (int i = 0; i < N_REGS; i++) begin
         logic_hit[i] = logic_we && (logic_req_i.addr == ADDR_W'(i));
         cpu_hit[i]   = cpu_wen_i && (cpu_addr_i == ADDR_W'(i));
      end
   end

   // storage
   for (genvar i = 0; i < N_REGS; i++) begin : g_word
      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            regs[i] <= '0;
         end else if (cke_i) begin
            if (logic_hit[i]) begin
               regs[i] <= logic_req_i.wdata;
            end else if (cpu_hit[i]) begin
               // stall keeps both hits apart on one word
               regs[i] <= cpu_wword_i.word;
            end
         end
      end
   end

   // cpu read mux, also feeds the strobe merge
   assign cpu_rword_o = regs[cpu_addr_i];

   // logic port read response

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else if (cke_i) begin
         rvalid_q <= logic_rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cke_i && logic_rd) begin
         rdata_q <= regs[logic_req_i.addr]; // value before this edge
      end
   end

   assign logic_resp_o.rvalid = rvalid_q;
   assign logic_resp_o.rdata  = rdata_q;

endmodule

//--- rtl/regfile_cpu_port.sv
`timescale 1ns/1ps

module regfile_cpu_port
   import regfile_cfg_pkg::*;
   import regfile_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              cke_i,

   // cpu bus
   input  cpu_req_t          req_i,
   output cpu_resp_t         resp_o,

   // towards the array
   input  logic              stall_i,    // write conflict on this address
   input  logic [DATA_W-1:0] rword_i,    // current word at req_i.addr
   output logic              is_write_o, // valid with nonzero strobe
   output logic              wen_o,
   output logic [ADDR_W-1:0] waddr_o,
   output reg_word_u         wword_o
);

   logic              ready;
   logic              accept;
   logic              is_write;
   logic              rd_accept;
   reg_word_u         wdata_u;
   reg_word_u         merged;
   logic              rvalid_q;
   logic [DATA_W-1:0] rdata_q;

   // handshake

   assign ready     = cke_i & ~stall_i; // cke low freezes the port
   assign accept    = req_i.valid & ready;
   assign is_write  = req_i.valid & (req_i.wstrb != '0);
   assign rd_accept = accept & ~is_write;

   // strobe merge
   // unstrobed lanes keep what the register holds now
   always_comb begin
      wdata_u.word = req_i.wdata;
      merged.word  = rword_i;
      for (int b = 0; b < STRB_W; b++) begin
         if (req_i.wstrb[b]) begin
            merged.bytes[b] = wdata_u.bytes[b];
         end
      end
   end

   // read response

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else if (cke_i) begin
         rvalid_q <= rd_accept; // high for exactly one cycle
      end
   end

   // data of the word before the accepting edge
   always_ff @(posedge clk_i) begin
      if (rd_accept) begin // ready already folds in cke
         rdata_q <= rword_i;
      end
   end

   // outputs

   assign resp_o.ready  = ready;
   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = rdata_q;

   assign is_write_o = is_write;
   assign wen_o      = accept & is_write;
   assign waddr_o    = req_i.addr;
   assign wword_o    = merged;

endmodule

//--- rtl/regfile_bus_pkg.sv
package regfile_bus_pkg;

   import regfile_cfg_pkg::*;

   // cpu side request
   // any strobe bit set makes it a write, no strobes means a read
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [STRB_W-1:0] wstrb;
      logic [DATA_W-1:0] wdata;
   } cpu_req_t;

   // cpu side response
   typedef struct packed {
      logic              ready;  // combinational
      logic              rvalid; // one cycle after read accept
      logic [DATA_W-1:0] rdata;
   } cpu_resp_t;

   // logic port request, whole words only
   typedef struct packed {
      logic              valid;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } logic_req_t;

   // logic port response, no back-pressure on this side
   typedef struct packed {
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
   } logic_resp_t;

   // one register word seen two ways
   // the strobe merge edits bytes and the array stores the word
   typedef union packed {
      logic [DATA_W-1:0]             word;
      logic [STRB_W-1:0][BYTE_W-1:0] bytes; // bytes[0] is the low byte
   } reg_word_u;

endpackage

//--- rtl/regfile_cfg_pkg.sv
package regfile_cfg_pkg;

   // register file geometry

   localparam int N_REGS = 16;             // number of registers
   localparam int DATA_W = 32;             // register width
   localparam int STRB_W = DATA_W / 8;     // byte lanes, one strobe bit each
   localparam int ADDR_W = $clog2(N_REGS); // register index

   // byte lane width follows from the two above
   localparam int BYTE_W = DATA_W / STRB_W;

endpackage
